// ==== build.f ====
video_switch_pkg.sv
avalon_mm_if.sv
video_stream_if.sv
switch_config_master.sv
switch_control_regs.sv
stream_switch_fabric.sv
video_switch_top.sv
tb_video_switch.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build with Verilator, run, and judge the result from the simulation log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --top-module tb_video_switch -f build.f -o sim_tb > build.log 2>&1 \
    && ./obj_dir/sim_tb > sim.log 2>&1 \
    || { cat build.log sim.log 2>/dev/null; echo "Build or simulation did not complete"; exit 1; }
cat sim.log
grep -q "Testbench failed" sim.log && exit 1
grep -q "Testbench passed" sim.log || exit 1
exit 0

// ==== tb_video_switch.sv ====
//********************************************************************
// Testbench of the video switch with random packets from a fixed LCG seed
// Model assumes the presets broadcast din0 and leave din1 drained
//********************************************************************
`timescale 1ns/1ns

module tb_video_switch;

    localparam int pw          = video_switch_pkg::pixel_width;
    localparam int num_packets = 40;    // Packets on each input
    localparam int num_tests   = 6;
    localparam int t_config    = 0;
    localparam int t_idle      = 1;
    localparam int t_out0      = 2;
    localparam int t_out1      = 3;
    localparam int t_drain     = 4;
    localparam int t_bp        = 5;

    typedef struct packed {
        logic [pw-1:0] data;
        logic          sop;
        logic          eop;
    } beat_t;

    logic          clk;
    logic          reset;
    logic [1:0]    din_valid;
    logic [1:0]    din_sop;
    logic [1:0]    din_eop;
    logic [pw-1:0] din_data [2];
    logic [1:0]    dout_ready;
    logic          din0_ready, din1_ready;
    logic          dout0_valid, dout0_sop, dout0_eop;
    logic          dout1_valid, dout1_sop, dout1_eop;
    logic [pw-1:0] dout0_data, dout1_data;
    logic          config_done;

    logic [31:0] lcg_state;
    int          pkt_len [2][num_packets];
    int          pkt_idx [2];
    int          beat_idx [2];
    int          test_errs [num_tests];
    string       test_names [num_tests];
    int          run_errs, cycles, limit, total_beats;
    int          din0_count, din1_count;
    logic [1:0]  din_fire;       // Transfers seen at the last sample point
    bit          config_seen;
    beat_t       q0[$], q1[$];   // Expected beats per output

    video_switch_top video_switch_top_inst (
        .clk         (clk),
        .reset       (reset),
        .din0_valid  (din_valid[0]),
        .din0_ready  (din0_ready),
        .din0_data   (din_data[0]),
        .din0_sop    (din_sop[0]),
        .din0_eop    (din_eop[0]),
        .din1_valid  (din_valid[1]),
        .din1_ready  (din1_ready),
        .din1_data   (din_data[1]),
        .din1_sop    (din_sop[1]),
        .din1_eop    (din_eop[1]),
        .dout0_valid (dout0_valid),
        .dout0_ready (dout_ready[0]),
        .dout0_data  (dout0_data),
        .dout0_sop   (dout0_sop),
        .dout0_eop   (dout0_eop),
        .dout1_valid (dout1_valid),
        .dout1_ready (dout_ready[1]),
        .dout1_data  (dout1_data),
        .dout1_sop   (dout1_sop),
        .dout1_eop   (dout1_eop),
        .config_done (config_done)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    task automatic check_flag(input int t, input string what, input logic exp, input logic act);
        if (exp !== act) begin
            $display("Mismatch in %s: %s expected %0b actual %0b", test_names[t], what, exp, act);
            test_errs[t]++;
        end
    endtask

    task automatic check_beat(input int t, input beat_t exp, input logic [pw-1:0] act_data,
                              input logic act_sop, input logic act_eop);
        if (exp.data !== act_data || exp.sop !== act_sop || exp.eop !== act_eop) begin
            $display("Mismatch in %s: expected data %h sop %b eop %b, actual data %h sop %b eop %b",
                     test_names[t], exp.data, exp.sop, exp.eop, act_data, act_sop, act_eop);
            test_errs[t]++;
        end
    endtask

    task automatic report_fail(input int t, input string msg);
        $display("Error in %s: %s", test_names[t], msg);
        test_errs[t]++;
    endtask

    task automatic report_test(input int t);
        if (test_errs[t] == 0) begin
            $display("Test %s: ok, 0 errors", test_names[t]);
        end else begin
            $display("Test %s: FAILED, %0d errors", test_names[t], test_errs[t]);
        end
    endtask

    // Next beat of input i where a stalled beat is held as it is
    task automatic pick_beat(input int i, input logic fired, output logic vld,
                             output logic [pw-1:0] data, output logic sop, output logic eop);
        logic [31:0] r;
        vld  = din_valid[i];
        data = din_data[i];
        sop  = din_sop[i];
        eop  = din_eop[i];
        if (fired) begin
            if (din_eop[i]) begin
                pkt_idx[i]  = pkt_idx[i] + 1;   // Packet closed
                beat_idx[i] = 0;
            end else begin
                beat_idx[i] = beat_idx[i] + 1;
            end
        end
        if (!din_valid[i] || fired) begin
            if (pkt_idx[i] < num_packets) begin
                r    = lcg_next();
                vld  = (r[31:30] != 2'b00);      // One cycle in four is a gap
                r    = lcg_next();
                data = r[31:32-pw];
                sop  = (beat_idx[i] == 0);
                eop  = (beat_idx[i] == pkt_len[i][pkt_idx[i]] - 1);
            end else begin
                vld = 1'b0;
                sop = 1'b0;
                eop = 1'b0;
            end
        end
    endtask

    // Runs at the falling edge, where every DUT output has settled
    task automatic sample_outputs();
        beat_t b;
        din_fire[0] = din_valid[0] && din0_ready;
        din_fire[1] = din_valid[1] && din1_ready;
        if (!config_done) begin
            if (config_seen) report_fail(t_config, "config_done fell after it had risen");
            check_flag(t_idle, "dout0_valid", 1'b0, dout0_valid);
            check_flag(t_idle, "dout1_valid", 1'b0, dout1_valid);
            check_flag(t_idle, "din0_ready", 1'b0, din0_ready);
            check_flag(t_idle, "din1_ready", 1'b0, din1_ready);
        end else if (!config_seen) begin
            config_seen = 1'b1;
            report_test(t_idle);    // Idle phase is over
        end
        if (config_done) begin
            check_flag(t_drain, "din1_ready", 1'b1, din1_ready);   // Unrouted input drains
        end
        if (!dout_ready[0] || !dout_ready[1]) begin
            check_flag(t_bp, "din0_ready", 1'b0, din0_ready);
        end
        if (din_fire[0]) begin
            b.data = din_data[0];
            b.sop  = din_sop[0];
            b.eop  = din_eop[0];
            // An output expects the beat when its preset selects din0
            if (video_switch_pkg::preset_dout0 == video_switch_pkg::route_din0) begin
                q0.push_back(b);
            end
            if (video_switch_pkg::preset_dout1 == video_switch_pkg::route_din0) begin
                q1.push_back(b);
            end
            din0_count++;
        end
        if (din_fire[1]) din1_count++;
        if (dout0_valid && dout_ready[0]) begin
            if (q0.size() == 0) begin
                report_fail(t_out0, "dout0 sent a beat that no input supplied");
            end else begin
                check_beat(t_out0, q0.pop_front(), dout0_data, dout0_sop, dout0_eop);
            end
        end
        if (dout1_valid && dout_ready[1]) begin
            if (q1.size() == 0) begin
                report_fail(t_out1, "dout1 sent a beat that no input supplied");
            end else begin
                check_beat(t_out1, q1.pop_front(), dout1_data, dout1_sop, dout1_eop);
            end
        end
    endtask

    initial begin
        logic          v, s, e;
        logic [pw-1:0] d;
        logic [31:0]   r;
        int            failed_tests;
        int            total_errs;
        reset       = 1'b1;
        din_valid   = '0;
        din_sop     = '0;
        din_eop     = '0;
        din_data[0] = '0;
        din_data[1] = '0;
        dout_ready  = '0;
        din_fire    = '0;
        lcg_state   = 32'h9770_336f;
        test_names  = '{"config_done", "idle_before_config", "dout0_order",
                        "dout1_order", "din1_drain", "backpressure"};
        total_beats = 0;
        for (int i = 0; i < 2; i++) begin
            pkt_idx[i]  = 0;
            beat_idx[i] = 0;
            for (int p = 0; p < num_packets; p++) begin
                r = lcg_next();
                pkt_len[i][p] = int'(r[31:29]) + 1;     // 1 to 8 beats
                total_beats   = total_beats + pkt_len[i][p];
            end
        end
        limit = 20 * total_beats + 100;

        repeat (3) @(posedge clk);
        reset <= 1'b0;

        while (!(pkt_idx[0] == num_packets && pkt_idx[1] == num_packets) && cycles < limit) begin
            @(negedge clk);
            sample_outputs();
            @(posedge clk);
            cycles++;
            for (int i = 0; i < 2; i++) begin
                pick_beat(i, din_fire[i], v, d, s, e);
                din_valid[i] <= v;
                din_data[i]  <= d;
                din_sop[i]   <= s;
                din_eop[i]   <= e;
            end
            r = lcg_next();
            dout_ready <= {r[31:30] != 2'b00, r[29:28] != 2'b00};
        end

        if (pkt_idx[0] != num_packets || pkt_idx[1] != num_packets) begin
            $display("Error: stimulus did not finish within %0d cycles", limit);
            run_errs++;
        end
        if (!config_seen) begin
            report_fail(t_config, "config_done never rose before the timeout");
            report_test(t_idle);
        end
        if (q0.size() != 0) report_fail(t_out0, $sformatf("%0d beats never left dout0", q0.size()));
        if (q1.size() != 0) report_fail(t_out1, $sformatf("%0d beats never left dout1", q1.size()));
        if (din1_count == 0) report_fail(t_drain, "din1 never accepted a beat");
        report_test(t_config);
        for (int t = t_out0; t < num_tests; t++) report_test(t);

        failed_tests = 0;
        total_errs   = run_errs;
        for (int t = 0; t < num_tests; t++) begin
            if (test_errs[t] != 0) failed_tests++;
            total_errs = total_errs + test_errs[t];
        end
        $display("Summary: %0d tests, %0d failing, %0d errors, %0d din0 beats, %0d din1 beats",
                 num_tests, failed_tests, total_errs, din0_count, din1_count);
        if (total_errs == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

// ==== video_switch_top.sv ====
//********************************************************************
// Video switch with self-loading presets, din0 broadcast to both outputs
// Streams stay stalled until config_done, then pass with zero latency
//********************************************************************
`timescale 1ns/1ns

module video_switch_top (
    input  logic                                     clk,
    input  logic                                     reset,
    input  logic                                     din0_valid,
    output logic                                     din0_ready,
    input  logic [video_switch_pkg::pixel_width-1:0] din0_data,
    input  logic                                     din0_sop,
    input  logic                                     din0_eop,
    input  logic                                     din1_valid,
    output logic                                     din1_ready,
    input  logic [video_switch_pkg::pixel_width-1:0] din1_data,
    input  logic                                     din1_sop,
    input  logic                                     din1_eop,
    output logic                                     dout0_valid,
    input  logic                                     dout0_ready,
    output logic [video_switch_pkg::pixel_width-1:0] dout0_data,
    output logic                                     dout0_sop,
    output logic                                     dout0_eop,
    output logic                                     dout1_valid,
    input  logic                                     dout1_ready,
    output logic [video_switch_pkg::pixel_width-1:0] dout1_data,
    output logic                                     dout1_sop,
    output logic                                     dout1_eop,
    output logic                                     config_done
);

    avalon_mm_if    cfg_bus ();
    video_stream_if din0_if ();
    video_stream_if din1_if ();
    video_stream_if dout0_if ();
    video_stream_if dout1_if ();

    logic                         go;
    video_switch_pkg::route_sel_t route0, route1;   // Active routing
    logic [1:0]                   out_busy;

    // Inputs onto the sink side
    assign din0_if.valid = din0_valid;
    assign din0_if.data  = din0_data;
    assign din0_if.sop   = din0_sop;
    assign din0_if.eop   = din0_eop;
    assign din0_ready    = din0_if.ready;
    assign din1_if.valid = din1_valid;
    assign din1_if.data  = din1_data;
    assign din1_if.sop   = din1_sop;
    assign din1_if.eop   = din1_eop;
    assign din1_ready    = din1_if.ready;

    // Outputs off the source side
    assign dout0_valid    = dout0_if.valid;
    assign dout0_data     = dout0_if.data;
    assign dout0_sop      = dout0_if.sop;
    assign dout0_eop      = dout0_if.eop;
    assign dout0_if.ready = dout0_ready;
    assign dout1_valid    = dout1_if.valid;
    assign dout1_data     = dout1_if.data;
    assign dout1_sop      = dout1_if.sop;
    assign dout1_eop      = dout1_if.eop;
    assign dout1_if.ready = dout1_ready;

    switch_config_master switch_config_master_inst (
        .clk         (clk),
        .reset       (reset),
        .bus         (cfg_bus.master),
        .config_done (config_done)
    );

    switch_control_regs switch_control_regs_inst (
        .clk      (clk),
        .reset    (reset),
        .bus      (cfg_bus.slave),
        .out_busy (out_busy),
        .go       (go),
        .route0   (route0),
        .route1   (route1)
    );

    stream_switch_fabric stream_switch_fabric_inst (
        .clk      (clk),
        .reset    (reset),
        .go       (go),
        .route0   (route0),
        .route1   (route1),
        .din0     (din0_if.sink),
        .din1     (din1_if.sink),
        .dout0    (dout0_if.source),
        .dout1    (dout1_if.source),
        .out_busy (out_busy)
    );

endmodule

// ==== stream_switch_fabric.sv ====
//********************************************************************
// Two by two stream crossbar with broadcast and drain, zero latency
// A broadcast beat moves only when every output taking it is ready
//********************************************************************
`timescale 1ns/1ns

module stream_switch_fabric (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         go,
    input  video_switch_pkg::route_sel_t route0,
    input  video_switch_pkg::route_sel_t route1,
    video_stream_if.sink                 din0,
    video_stream_if.sink                 din1,
    video_stream_if.source               dout0,
    video_stream_if.source               dout1,
    output logic [1:0]                   out_busy
);

    localparam int n = video_switch_pkg::num_ports;

    video_switch_pkg::route_sel_t             route   [n];
    logic                                     in_vld  [n];
    logic                                     in_rdy  [n];
    logic [video_switch_pkg::pixel_width-1:0] in_dat  [n];
    logic                                     in_sop  [n];
    logic                                     in_eop  [n];
    logic                                     out_vld [n];
    logic                                     out_rdy [n];
    logic [video_switch_pkg::pixel_width-1:0] out_dat [n];
    logic                                     out_sop [n];
    logic                                     out_eop [n];

    // Gather the ports into arrays so both paths share one body
    assign route[0]   = route0;
    assign route[1]   = route1;
    assign in_vld[0]  = din0.valid;
    assign in_vld[1]  = din1.valid;
    assign in_dat[0]  = din0.data;
    assign in_dat[1]  = din1.data;
    assign in_sop[0]  = din0.sop;
    assign in_sop[1]  = din1.sop;
    assign in_eop[0]  = din0.eop;
    assign in_eop[1]  = din1.eop;
    assign out_rdy[0] = dout0.ready;
    assign out_rdy[1] = dout1.ready;

    always_comb begin
        logic others_rdy;
        others_rdy = 1'b1;
        // Input ready is the AND over its outputs, unrouted inputs drain
        for (int i = 0; i < n; i++) begin
            in_rdy[i] = go;
            for (int k = 0; k < n; k++) begin
                if (route[k] == video_switch_pkg::input_sel[i]) in_rdy[i] &= out_rdy[k];
            end
        end

        for (int k = 0; k < n; k++) begin
            out_vld[k] = 1'b0;
            out_dat[k] = '0;
            out_sop[k] = 1'b0;
            out_eop[k] = 1'b0;
            for (int i = 0; i < n; i++) begin
                if (route[k] == video_switch_pkg::input_sel[i]) begin
                    others_rdy = 1'b1;   // Sibling outputs of a broadcast
                    for (int j = 0; j < n; j++) begin
                        if (j != k && route[j] == route[k]) others_rdy &= out_rdy[j];
                    end
                    out_vld[k] = go & in_vld[i] & others_rdy;
                    out_dat[k] = in_dat[i];
                    out_sop[k] = in_sop[i];
                    out_eop[k] = in_eop[i];
                end
            end
        end
    end

    assign din0.ready  = in_rdy[0];
    assign din1.ready  = in_rdy[1];
    assign dout0.valid = out_vld[0];
    assign dout1.valid = out_vld[1];
    assign dout0.data  = out_dat[0];
    assign dout1.data  = out_dat[1];
    assign dout0.sop   = out_sop[0];
    assign dout1.sop   = out_sop[1];
    assign dout0.eop   = out_eop[0];
    assign dout1.eop   = out_eop[1];

    // Packet in progress per output, single beat packets never set it
    always_ff @(posedge clk) begin
        if (reset) begin
            out_busy <= '0;
        end else begin
            for (int k = 0; k < n; k++) begin
                if (out_vld[k] && out_rdy[k]) begin
                    if (out_eop[k]) out_busy[k] <= 1'b0;
                    else if (out_sop[k]) out_busy[k] <= 1'b1;
                end
            end
        end
    end

endmodule

// ==== switch_control_regs.sv ====
//********************************************************************
// Control registers of the switch, write only
// Each write takes one wait state, only byte lane 0 is stored
// Pending routing goes live once no output is inside a packet
//********************************************************************
`timescale 1ns/1ns

module switch_control_regs (
    input  logic                         clk,
    input  logic                         reset,
    avalon_mm_if.slave                   bus,
    input  logic [1:0]                   out_busy,
    output logic                         go,
    output video_switch_pkg::route_sel_t route0,
    output video_switch_pkg::route_sel_t route1
);

    logic                         wait_done;        // Second cycle of a write
    logic                         wr_en;
    logic                         commit_pending;
    video_switch_pkg::reg_addr_t  addr;
    video_switch_pkg::route_sel_t pend0, pend1;     // Written but not yet live
    video_switch_pkg::route_sel_t wr_route;

    // First write cycle stalls, second one completes
    assign bus.waitrequest = bus.write & ~wait_done;

    always_ff @(posedge clk) begin
        if (reset) begin
            wait_done <= 1'b0;
        end else begin
            wait_done <= bus.write & ~wait_done;
        end
    end

    assign addr     = video_switch_pkg::reg_addr_t'(bus.address);
    assign wr_route = video_switch_pkg::route_sel_t'(
                          bus.writedata[video_switch_pkg::route_sel_width-1:0]);
    assign wr_en    = bus.write & ~bus.waitrequest & bus.byteenable[0];

    always_ff @(posedge clk) begin
        if (reset) begin
            go             <= 1'b0;
            pend0          <= video_switch_pkg::route_off;
            pend1          <= video_switch_pkg::route_off;
            route0         <= video_switch_pkg::route_off;
            route1         <= video_switch_pkg::route_off;
            commit_pending <= 1'b0;
        end else begin
            // Swap routing only between packets
            if (commit_pending && out_busy == 2'b00) begin
                route0         <= pend0;
                route1         <= pend1;
                commit_pending <= 1'b0;
            end

            if (wr_en) begin
                case (addr)
                    video_switch_pkg::reg_control:
                        go <= bus.writedata[video_switch_pkg::go_bit];
                    video_switch_pkg::reg_switch:
                        if (bus.writedata[video_switch_pkg::commit_bit]) begin
                            commit_pending <= 1'b1;   // Wins over a same-cycle commit
                        end
                    video_switch_pkg::reg_dout0: pend0 <= wr_route;
                    video_switch_pkg::reg_dout1: pend1 <= wr_route;
                    default: ;                        // Unmapped, write dropped
                endcase
            end
        end
    end

endmodule

// ==== switch_config_master.sv ====
//********************************************************************
// Writes the preset register sequence once after reset, then idles
// Never reads back, relies on the slave's waitrequest to pace writes
//********************************************************************
`timescale 1ns/1ns

module switch_config_master (
    input  logic  clk,
    input  logic  reset,
    avalon_mm_if.master bus,
    output logic  config_done
);

    typedef enum logic [2:0] {
        init,
        stop,
        write_dout0,
        write_dout1,
        write_switch,
        enable,
        done
    } state_t;

    state_t state, next_state;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= init;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state     = state;
        bus.address    = video_switch_pkg::reg_control;   // Quiet bus by default
        bus.write      = 1'b0;
        bus.writedata  = '0;
        bus.byteenable = '0;

        case (state)
            init: next_state = stop;    // One settling cycle

            // Clear go before touching the routing
            stop: begin
                bus.address   = video_switch_pkg::reg_control;
                bus.writedata = video_switch_pkg::ctrl_stop;
                if (!bus.waitrequest) next_state = write_dout0;
            end

            write_dout0: begin
                bus.address = video_switch_pkg::reg_dout0;
                bus.writedata[video_switch_pkg::route_sel_width-1:0] =
                    video_switch_pkg::preset_dout0;
                if (!bus.waitrequest) next_state = write_dout1;
            end

            write_dout1: begin
                bus.address = video_switch_pkg::reg_dout1;
                bus.writedata[video_switch_pkg::route_sel_width-1:0] =
                    video_switch_pkg::preset_dout1;
                if (!bus.waitrequest) next_state = write_switch;
            end

            // Commit has to follow both dout writes
            write_switch: begin
                bus.address   = video_switch_pkg::reg_switch;
                bus.writedata = video_switch_pkg::switch_req;
                if (!bus.waitrequest) next_state = enable;
            end

            enable: begin
                bus.address   = video_switch_pkg::reg_control;
                bus.writedata = video_switch_pkg::ctrl_go;   // Start streaming
                if (!bus.waitrequest) next_state = done;
            end

            done: next_state = done;    // Parked for good

            default: next_state = init;
        endcase

        // Every write state holds a full word write until accepted
        if (state inside {stop, write_dout0, write_dout1, write_switch, enable}) begin
            bus.write      = 1'b1;
            bus.byteenable = video_switch_pkg::be_all;
        end
    end

    assign config_done = (state == done);

endmodule

// ==== video_stream_if.sv ====
//********************************************************************
// One valid/ready pixel stream with packet framing
// Source holds valid, data, sop and eop until the beat transfers
//********************************************************************
`timescale 1ns/1ns

interface video_stream_if;

    logic                                     valid;
    logic                                     ready;   // Driven by the sink
    logic [video_switch_pkg::pixel_width-1:0] data;
    logic                                     sop;     // First beat of a packet
    logic                                     eop;     // Last beat of a packet

    modport source (
        output valid,
        output data,
        output sop,
        output eop,
        input  ready
    );

    modport sink (
        input  valid,
        input  data,
        input  sop,
        input  eop,
        output ready
    );

endinterface

// ==== avalon_mm_if.sv ====
//********************************************************************
// Avalon-MM style write-only bus, no read path and no bursts
// A write completes on the edge where write is high and waitrequest low
//********************************************************************
`timescale 1ns/1ns

interface avalon_mm_if;

    logic [video_switch_pkg::bus_addr_width-1:0] address;
    logic                                        write;
    logic [video_switch_pkg::bus_data_width-1:0] writedata;
    logic [video_switch_pkg::bus_be_width-1:0]   byteenable;
    logic                                        waitrequest;   // From the slave

    // Master holds address and data while waitrequest is high
    modport master (
        output address,
        output write,
        output writedata,
        output byteenable,
        input  waitrequest
    );

    modport slave (
        input  address,
        input  write,
        input  writedata,
        input  byteenable,
        output waitrequest
    );

endinterface

// ==== video_switch_pkg.sv ====
//********************************************************************
// Shared widths, register map and route encodings of the video switch
// Registers decode byte lane 0 only, upper bytes are written as zero
// Route values outside route_sel_t behave as route_off
//********************************************************************
package video_switch_pkg;

    // Stream payload
    localparam int pixel_width = 24;    // One RGB pixel per beat
    localparam int num_ports   = 2;     // Two inputs, two outputs

    // Register bus geometry
    localparam int bus_addr_width = 5;  // Five decoded address bits
    localparam int bus_data_width = 32;
    localparam int bus_be_width   = bus_data_width / 8;

    // All presets are full word writes
    localparam logic [bus_be_width-1:0] be_all = '1;

    // Register map
    typedef enum logic [bus_addr_width-1:0] {
        reg_control = 5'd0,     // Bit 0 is go
        reg_switch  = 5'd3,     // Bit 0 requests a routing commit
        reg_dout0   = 5'd4,     // Source select of output 0
        reg_dout1   = 5'd5      // Source select of output 1
    } reg_addr_t;

    // Bit positions inside the control and switch words
    localparam int go_bit     = 0;
    localparam int commit_bit = 0;

    // Output source select
    localparam int route_sel_width = 2;

    typedef enum logic [route_sel_width-1:0] {
        route_off  = 2'd0,      // Output idle
        route_din0 = 2'd1,
        route_din1 = 2'd2
    } route_sel_t;

    // Select value that names each input, indexed by input number
    localparam route_sel_t input_sel [num_ports] = '{route_din0, route_din1};

    // Power-up routing, din0 broadcast to both outputs
    localparam route_sel_t preset_dout0 = route_din0;
    localparam route_sel_t preset_dout1 = route_din0;

    // Data words of the preset writes
    localparam logic [bus_data_width-1:0] ctrl_stop  = '0;
    localparam logic [bus_data_width-1:0] ctrl_go    = 1 << go_bit;
    localparam logic [bus_data_width-1:0] switch_req = 1 << commit_bit;

endpackage
